// ==== tcb_pkg.sv ====
package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // data bus width in bits
  localparam int unsigned TCB_DAT_W = 32;
  // byte lanes per data word
  localparam int unsigned TCB_BEN = TCB_DAT_W / 8;
  // byte address width
  localparam int unsigned TCB_ADR_W = 12;
  // byte offset bits inside a word
  localparam int unsigned TCB_OFF_W = $clog2(TCB_BEN);
  // memory depth in words, indexed by adr[11:2]
  localparam int unsigned TCB_MEM_DEPTH = 1024;
  // response delay in clock cycles
  localparam int unsigned TCB_HSK_DLY = 1;

  ////////////////////////////////////////
  // size and status codes
  ////////////////////////////////////////

  // log2 of transfer size in bytes
  localparam logic [1:0] TCB_SIZ_BYTE = 2'd0;
  localparam logic [1:0] TCB_SIZ_HALF = 2'd1;
  localparam logic [1:0] TCB_SIZ_WORD = 2'd2;
  // code 3 is illegal, answered with an error

  // response status
  localparam logic TCB_STS_OK  = 1'b0;
  localparam logic TCB_STS_ERR = 1'b1;

  ////////////////////////////////////////
  // data word views
  ////////////////////////////////////////

  // one data word, seen as bytes or as halves
  typedef union packed {
    // byte lanes, lane 0 at bits 7:0
    logic [TCB_BEN-1:0][7:0] byt;
    // halfword lanes, lane 0 at bits 15:0
    logic [TCB_BEN/2-1:0][15:0] hlf;
  } tcb_data_t;

endpackage

// ==== tcb_req_steer.sv ====
`timescale 1ns/1ps

module tcb_req_steer (
  // log-size request
  input  logic                             vld,
  input  logic                             wen,
  input  logic [tcb_pkg::TCB_ADR_W-1:0]    adr,
  input  logic [1:0]                       siz,
  input  logic [tcb_pkg::TCB_DAT_W-1:0]    wdt,
  input  logic                             rdy,
  // byte-enable request
  output logic                             mem_vld,
  output logic                             mem_wen,
  output logic [tcb_pkg::TCB_ADR_W-1:0]    mem_adr,
  output logic [tcb_pkg::TCB_BEN-1:0]      mem_ben,
  output logic [tcb_pkg::TCB_DAT_W-1:0]    mem_wdt,
  // misaligned or illegal size
  output logic                             req_err
);

  // byte offset inside the word
  logic [tcb_pkg::TCB_OFF_W-1:0] off;
  // write data, raw and replicated
  tcb_pkg::tcb_data_t wdt_u;
  tcb_pkg::tcb_data_t wdt_r;
  // enables before the error mask
  logic [tcb_pkg::TCB_BEN-1:0] ben;

  assign off   = adr[tcb_pkg::TCB_OFF_W-1:0];
  assign wdt_u = wdt;

  ////////////////////////////////////////
  // control and address
  ////////////////////////////////////////

  // handshake and command go straight through
  assign mem_vld = vld;
  assign mem_wen = wen;
  // word-aligned address
  assign mem_adr = {adr[tcb_pkg::TCB_ADR_W-1:tcb_pkg::TCB_OFF_W], tcb_pkg::TCB_OFF_W'(0)};

  ////////////////////////////////////////
  // byte enables and alignment check
  ////////////////////////////////////////

  always_comb begin
    case (siz)
      tcb_pkg::TCB_SIZ_BYTE: begin
        // single lane picked by the full offset
        ben     = 4'b0001 << off;
        req_err = 1'b0;
      end
      tcb_pkg::TCB_SIZ_HALF: begin
        ben     = off[1] ? 4'b1100 : 4'b0011;
        // odd address is misaligned
        req_err = off[0];
      end
      tcb_pkg::TCB_SIZ_WORD: begin
        ben     = 4'b1111;
        req_err = |off;
      end
      default: begin
        // size 3
        ben     = 4'b0000;
        req_err = 1'b1;
      end
    endcase
  end

  // flagged requests write nothing
  assign mem_ben = req_err ? '0 : ben;

  ////////////////////////////////////////
  // write data replication
  ////////////////////////////////////////

  always_comb begin
    case (siz)
      // low byte copied to every lane
      tcb_pkg::TCB_SIZ_BYTE: wdt_r.byt = {tcb_pkg::TCB_BEN{wdt_u.byt[0]}};
      // low half copied to both halves
      tcb_pkg::TCB_SIZ_HALF: wdt_r.hlf = {2{wdt_u.hlf[0]}};
      default:               wdt_r = wdt_u;
    endcase
  end

  assign mem_wdt = wdt_r;

  // an accepted legal request enables 2**siz lanes, the addressed one among them
  always_comb begin
    if (vld && rdy && !req_err) begin
      assert final (mem_ben[off] && ($countones(mem_ben) == (1 << siz)))
        else $error("legal transfer with wrong byte enables");
    end
  end

endmodule

// ==== tcb_mem_ben.sv ====
`timescale 1ns/1ps

module tcb_mem_ben (
  input  logic                             clk,
  input  logic                             arst_n,
  // byte-enable request
  input  logic                             vld,
  input  logic                             wen,
  input  logic [tcb_pkg::TCB_ADR_W-1:0]    adr,
  input  logic [tcb_pkg::TCB_BEN-1:0]      ben,
  input  logic [tcb_pkg::TCB_DAT_W-1:0]    wdt,
  // handshake and read data
  output logic                             rdy,
  output logic [tcb_pkg::TCB_DAT_W-1:0]    rdt
);

  // word storage, contents not reset
  logic [tcb_pkg::TCB_DAT_W-1:0] mem [0:tcb_pkg::TCB_MEM_DEPTH-1];

  // transfer this cycle
  logic xfr;
  // word index from adr[11:2]
  logic [tcb_pkg::TCB_ADR_W-tcb_pkg::TCB_OFF_W-1:0] idx;
  // stored word and word after the byte merge
  logic [tcb_pkg::TCB_DAT_W-1:0] cur;
  logic [tcb_pkg::TCB_DAT_W-1:0] nxt;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  // never stalls
  assign rdy = 1'b1;
  assign xfr = vld & rdy;

  assign idx = adr[tcb_pkg::TCB_ADR_W-1:tcb_pkg::TCB_OFF_W];
  assign cur = mem[idx];

  ////////////////////////////////////////
  // byte merge
  ////////////////////////////////////////

  always_comb begin
    nxt = cur;
    if (wen) begin
      for (int i = 0; i < tcb_pkg::TCB_BEN; i++) begin
        // enabled lanes take the new byte
        if (ben[i]) begin
          nxt[8*i +: 8] = wdt[8*i +: 8];
        end
      end
    end
  end

  // storage write, only on a write transfer
  always_ff @(posedge clk) begin
    if (xfr && wen) begin
      mem[idx] <= nxt;
    end
  end

  ////////////////////////////////////////
  // read response
  ////////////////////////////////////////

  // read after write, so a write returns the merged word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdt <= '0;
    end else if (xfr) begin
      rdt <= nxt;
    end
  end

  // write with an unknown address would corrupt an unknown word
  property p_wr_adr_known;
    @(posedge clk) disable iff (!arst_n)
      (xfr && wen) |-> !$isunknown(adr);
  endproperty

  a_wr_adr_known: assert property (p_wr_adr_known)
    else $error("write transfer with unknown address");

endmodule

// ==== tcb_rsp_align.sv ====
`timescale 1ns/1ps

module tcb_rsp_align (
  input  logic                             clk,
  input  logic                             arst_n,
  // request side, sampled on transfer
  input  logic                             vld,
  input  logic                             rdy,
  input  logic [tcb_pkg::TCB_OFF_W-1:0]    off,
  input  logic [1:0]                       siz,
  input  logic                             req_err,
  // full word from memory
  input  logic [tcb_pkg::TCB_DAT_W-1:0]    mem_rdt,
  // log-size response
  output logic                             rsp_vld,
  output logic [tcb_pkg::TCB_DAT_W-1:0]    rdt,
  output logic                             sts
);

  // request transfer this cycle
  logic xfr;
  // recorded request attributes
  logic [tcb_pkg::TCB_OFF_W-1:0] off_q;
  logic [1:0]                    siz_q;
  logic                          err_q;
  // read multiplexer stages
  tcb_pkg::tcb_data_t            wrd;
  logic [1:0][7:0]               hlf;
  logic [7:0]                    byt;

  assign xfr = vld & rdy;

  ////////////////////////////////////////
  // delay record
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
      off_q   <= '0;
      siz_q   <= tcb_pkg::TCB_SIZ_BYTE;
      err_q   <= 1'b0;
    end else begin
      // one response per transfer
      rsp_vld <= xfr;
      if (xfr) begin
        off_q <= off;
        siz_q <= siz;
        err_q <= req_err;
      end
    end
  end

  ////////////////////////////////////////
  // read lane extraction
  ////////////////////////////////////////

  assign wrd = mem_rdt;
  // half by offset bit 1
  assign hlf = off_q[1] ? wrd.hlf[1] : wrd.hlf[0];
  // then byte by offset bit 0
  assign byt = off_q[0] ? hlf[1] : hlf[0];

  always_comb begin
    if (err_q) begin
      // flagged request returns nothing
      rdt = '0;
    end else begin
      case (siz_q)
        tcb_pkg::TCB_SIZ_BYTE: rdt = {24'd0, byt};
        tcb_pkg::TCB_SIZ_HALF: rdt = {16'd0, hlf};
        tcb_pkg::TCB_SIZ_WORD: rdt = wrd;
        default:               rdt = '0;
      endcase
    end
  end

  assign sts = err_q ? tcb_pkg::TCB_STS_ERR : tcb_pkg::TCB_STS_OK;

  // attributes recorded on a transfer are all defined
  property p_xfr_known;
    @(posedge clk) disable iff (!arst_n)
      xfr |-> !$isunknown({off, siz, req_err});
  endproperty

  a_xfr_known: assert property (p_xfr_known)
    else $error("transfer with unknown offset, size or error flag");

endmodule

// ==== tcb_logsize_top.sv ====
`timescale 1ns/1ps

module tcb_logsize_top (
  input  logic                             clk,
  input  logic                             arst_n,
  // log-size request
  input  logic                             vld,
  input  logic                             wen,
  input  logic [tcb_pkg::TCB_ADR_W-1:0]    adr,
  input  logic [1:0]                       siz,
  input  logic [tcb_pkg::TCB_DAT_W-1:0]    wdt,
  output logic                             rdy,
  // log-size response
  output logic                             rsp_vld,
  output logic [tcb_pkg::TCB_DAT_W-1:0]    rdt,
  output logic                             sts
);

  // steerer to memory
  logic                          mem_vld;
  logic                          mem_wen;
  logic [tcb_pkg::TCB_ADR_W-1:0] mem_adr;
  logic [tcb_pkg::TCB_BEN-1:0]   mem_ben;
  logic [tcb_pkg::TCB_DAT_W-1:0] mem_wdt;
  // memory back to steerer and aligner
  logic                          mem_rdy;
  logic [tcb_pkg::TCB_DAT_W-1:0] mem_rdt;
  // steerer to aligner
  logic                          req_err;

  // ready comes from the target
  assign rdy = mem_rdy;

  tcb_req_steer u_steer (
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (mem_rdy),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .req_err (req_err)
  );

  tcb_mem_ben u_mem (
    .clk    (clk),
    .arst_n (arst_n),
    .vld    (mem_vld),
    .wen    (mem_wen),
    .adr    (mem_adr),
    .ben    (mem_ben),
    .wdt    (mem_wdt),
    .rdy    (mem_rdy),
    .rdt    (mem_rdt)
  );

  // offset taken from the unmasked request address
  tcb_rsp_align u_align (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .rdy     (mem_rdy),
    .off     (adr[tcb_pkg::TCB_OFF_W-1:0]),
    .siz     (siz),
    .req_err (req_err),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

endmodule

// ==== tb_tcb_logsize.sv ====
`timescale 1ns/1ps

module tb_tcb_logsize;

  ////////////////////////////////////////
  // run setup
  ////////////////////////////////////////

  localparam time CLK_PERIOD = 100ns;
  // tests need about 400 cycles
  localparam int TIMEOUT_CYC = 2000;
  // random traffic stays in 16 words
  localparam logic [11:0] RND_BASE = 12'h100;

  logic clk;
  logic arst_n;
  logic vld;
  logic wen;
  logic [tcb_pkg::TCB_ADR_W-1:0] adr;
  logic [1:0] siz;
  logic [tcb_pkg::TCB_DAT_W-1:0] wdt;
  logic rdy;
  logic rsp_vld;
  logic [tcb_pkg::TCB_DAT_W-1:0] rdt;
  logic sts;

  // reference memory, one entry per byte
  logic [7:0] ref_mem [0:4095];
  // expected responses in transfer order
  logic [31:0] exp_rdt_q [$];
  logic exp_sts_q [$];
  string cur_test;
  int errors = 0;
  int err_start = 0;
  int checks = 0;
  int tests = 0;
  int cyc = 0;
  logic [31:0] lfsr = 32'd92128;

  tcb_logsize_top u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdy     (rdy),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////

  // galois step, x^32+x^22+x^2+x+1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // size rules: aligned only, code 3 illegal
  task automatic model_xfr(input logic w, input logic [11:0] a, input logic [1:0] s,
                           input logic [31:0] d, output logic [31:0] e_rdt,
                           output logic e_sts);
    int nb;
    logic err;
    nb  = 1 << s;
    err = (s == 2'd3) || (s == tcb_pkg::TCB_SIZ_HALF && a[0]) ||
          (s == tcb_pkg::TCB_SIZ_WORD && a[1:0] != 2'd0);
    e_rdt = '0;
    e_sts = err ? tcb_pkg::TCB_STS_ERR : tcb_pkg::TCB_STS_OK;
    if (!err) begin
      for (int i = 0; i < nb; i++) begin
        if (w) ref_mem[a + i] = d[8*i +: 8];
        // read back low lanes, upper lanes stay zero
        e_rdt[8*i +: 8] = ref_mem[a + i];
      end
    end
  endtask

  ////////////////////////////////////////
  // request driver and response check
  ////////////////////////////////////////

  task automatic send(input logic w, input logic [11:0] a, input logic [1:0] s,
                      input logic [31:0] d);
    logic [31:0] e_rdt;
    logic e_sts;
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    siz <= s;
    wdt <= d;
    // transfer on the first edge with ready
    @(posedge clk);
    while (!rdy) @(posedge clk);
    model_xfr(w, a, s, d, e_rdt, e_sts);
    exp_rdt_q.push_back(e_rdt);
    exp_sts_q.push_back(e_sts);
  endtask

  // response due at the negedge after the transfer
  always @(negedge clk) begin
    if (rsp_vld) begin
      if (exp_rdt_q.size() == 0) begin
        $display("%s: response valid without an accepted request", cur_test);
        errors++;
      end else begin
        checks++;
        if (rdt !== exp_rdt_q[0]) begin
          $display("** Error %s: rdt expected %08h, actual %08h",
                   cur_test, exp_rdt_q[0], rdt);
          errors++;
        end
        if (sts !== exp_sts_q[0]) begin
          $display("** Error %s: sts expected %0b, actual %0b", cur_test, exp_sts_q[0], sts);
          errors++;
        end
        exp_rdt_q.delete(0);
        exp_sts_q.delete(0);
      end
    end else if (exp_rdt_q.size() != 0) begin
      $display("%s: no response one cycle after a transfer", cur_test);
      errors++;
      exp_rdt_q.delete(0);
      exp_sts_q.delete(0);
    end
  end

  task automatic start_test(input string name);
    cur_test  = name;
    err_start = errors;
    tests++;
  endtask

  task automatic end_test();
    vld <= 1'b0;
    wen <= 1'b0;
    @(posedge clk);
    while (exp_rdt_q.size() != 0) @(posedge clk);
    $display("%s: done, %0d errors", cur_test, errors - err_start);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    start_test("test_reset");
    @(negedge clk);
    checks++;
    if (rsp_vld !== 1'b0) begin
      $display("** Error %s: rsp_vld expected 0, actual %b", cur_test, rsp_vld);
      errors++;
    end
    if (rdy !== 1'b1) begin
      $display("** Error %s: rdy expected 1, actual %b", cur_test, rdy);
      errors++;
    end
    @(posedge clk);
    end_test();
  endtask

  task automatic test_word();
    start_test("test_word");
    for (int i = 0; i < 6; i++) begin
      send(1'b1, 12'(i * 12'h2a4), tcb_pkg::TCB_SIZ_WORD, rnd(32));
    end
    for (int i = 0; i < 6; i++) begin
      send(1'b0, 12'(i * 12'h2a4), tcb_pkg::TCB_SIZ_WORD, '0);
    end
    end_test();
  endtask

  task automatic test_byte_lanes();
    start_test("test_byte_lanes");
    send(1'b1, 12'h240, tcb_pkg::TCB_SIZ_WORD, '0);
    // junk above the low byte must not leak
    for (int i = 0; i < 4; i++) begin
      send(1'b1, 12'(12'h240 + i), 2'd0, {24'hffffff, 8'(8'hc0 + 19 * i)});
    end
    send(1'b0, 12'h240, tcb_pkg::TCB_SIZ_WORD, '0);
    for (int i = 0; i < 4; i++) begin
      send(1'b0, 12'(12'h240 + i), tcb_pkg::TCB_SIZ_BYTE, '0);
    end
    end_test();
  endtask

  task automatic test_half();
    start_test("test_half");
    send(1'b1, 12'h4c8, tcb_pkg::TCB_SIZ_WORD, rnd(32));
    send(1'b1, 12'h4c8, tcb_pkg::TCB_SIZ_HALF, rnd(32));
    send(1'b0, 12'h4c8, tcb_pkg::TCB_SIZ_HALF, '0);
    // upper half untouched
    send(1'b0, 12'h4ca, tcb_pkg::TCB_SIZ_HALF, '0);
    send(1'b1, 12'h4ca, tcb_pkg::TCB_SIZ_HALF, rnd(32));
    send(1'b0, 12'h4c8, tcb_pkg::TCB_SIZ_WORD, '0);
    send(1'b0, 12'h4ca, tcb_pkg::TCB_SIZ_HALF, '0);
    end_test();
  endtask

  task automatic test_misaligned();
    start_test("test_misaligned");
    send(1'b1, 12'h6f0, tcb_pkg::TCB_SIZ_WORD, rnd(32));
    send(1'b1, 12'h6f1, tcb_pkg::TCB_SIZ_HALF, rnd(32));
    send(1'b1, 12'h6f1, tcb_pkg::TCB_SIZ_WORD, rnd(32));
    send(1'b1, 12'h6f0, 2'd3, rnd(32));
    send(1'b0, 12'h6f3, tcb_pkg::TCB_SIZ_HALF, '0);
    send(1'b0, 12'h6f0, tcb_pkg::TCB_SIZ_WORD, '0);
    end_test();
  endtask

  task automatic test_random_mix();
    logic w;
    logic [1:0] s;
    logic [1:0] off;
    logic [11:0] a;
    start_test("test_random_mix");
    // define every word of the region first
    for (int i = 0; i < 16; i++) begin
      send(1'b1, 12'(RND_BASE + 4 * i), tcb_pkg::TCB_SIZ_WORD, rnd(32));
    end
    for (int n = 0; n < 200; n++) begin
      w = 1'(rnd(1));
      s = 2'(rnd(2));
      if (s == 2'd3) s = tcb_pkg::TCB_SIZ_WORD;
      case (s)
        tcb_pkg::TCB_SIZ_BYTE: off = 2'(rnd(2));
        tcb_pkg::TCB_SIZ_HALF: off = {1'(rnd(1)), 1'b0};
        default:               off = 2'd0;
      endcase
      a = RND_BASE + {4'(rnd(4)), off};
      send(w, a, s, rnd(32));
    end
    end_test();
  endtask

  initial begin
    arst_n = 1'b0;
    vld    = 1'b0;
    wen    = 1'b0;
    adr    = '0;
    siz    = '0;
    wdt    = '0;
    cur_test = "reset";
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    test_reset();
    test_word();
    test_byte_lanes();
    test_half();
    test_misaligned();
    test_random_mix();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
tcb_pkg.sv
tcb_req_steer.sv
tcb_mem_ben.sv
tcb_rsp_align.sv
tcb_logsize_top.sv
tb_tcb_logsize.sv

// ==== Bender.yml ====
package:
  name: tcb_logsize

sources:
  - tcb_pkg.sv
  - tcb_req_steer.sv
  - tcb_mem_ben.sv
  - tcb_rsp_align.sv
  - tcb_logsize_top.sv
  - target: test
    files:
      - tb_tcb_logsize.sv
